//--- verilog/video_timing_pkg.sv
package video_timing_pkg;

	////////////////////////////////////////////////////////////////////////////
	// pixel clock
	////////////////////////////////////////////////////////////////////////////

	// master clocks per pixel, 48m down to 6m
	localparam int pix_div = 8;

	////////////////////////////////////////////////////////////////////////////
	// raster positions
	////////////////////////////////////////////////////////////////////////////

	// pixel within line
	typedef logic [7:0] hpos_t;

	// line within frame
	typedef logic [7:0] vpos_t;

endpackage

//--- verilog/gfx_pkg.sv
package gfx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// host write regions
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		sel_tilemap   = 3'd0,
		sel_sprite    = 3'd1,
		sel_palette   = 3'd2,
		sel_scroll    = 3'd3,
		sel_backcolor = 3'd4
	} wr_sel_t;

	// raw host write word
	typedef logic [15:0] host_data_t;

	////////////////////////////////////////////////////////////////////////////
	// colour and layer entries
	////////////////////////////////////////////////////////////////////////////

	// index 0 is transparent
	typedef logic [3:0] cidx_t;

	// built-in 8x8 tile patterns
	typedef enum logic [1:0] {
		pat_solid   = 2'd0,
		pat_empty   = 2'd1,
		pat_checker = 2'd2,
		pat_stripe  = 2'd3
	} pattern_t;

	// tilemap cell, colour in the upper bits
	typedef struct packed {
		cidx_t    color;
		pattern_t pattern;
	} tile_entry_t;

	// sprite table entry, 8x8 solid square
	typedef struct packed {
		logic       enable;
		logic [5:0] x;
		logic [4:0] y;
		cidx_t      color;
	} sprite_entry_t;

	// blue in the top nibble, red in the bottom
	typedef struct packed {
		logic [3:0] blue;
		logic [3:0] green;
		logic [3:0] red;
	} rgb_t;

	// tilemap size in 8x8 tiles, 64x32 pixels
	localparam int map_cols = 8;
	localparam int map_rows = 4;

endpackage

//--- verilog/entry_store.sv
`timescale 1ns/1ps

module entry_store #(
	parameter type entry_t = logic [7:0],
	parameter int  depth   = 16
) (
	input  logic                     clk_48m,
	input  logic                     rst_n,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  entry_t                   wdata,
	input  logic [$clog2(depth)-1:0] raddr,
	output entry_t                   rdata
);

	entry_t mem [depth];

	// write port, whole array cleared on reset
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			for (int i = 0; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// async read
	assign rdata = mem[raddr];

endmodule

//--- verilog/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
	parameter int h_active = 32,
	parameter int h_total  = 48,
	parameter int v_active = 16,
	parameter int v_total  = 24
) (
	input  logic                    clk_48m,
	input  logic                    rst_n,
	output logic                    pix_ce,
	output video_timing_pkg::hpos_t hpos,
	output video_timing_pkg::vpos_t vpos,
	output logic                    active,
	output logic                    hsync_n,
	output logic                    vsync_n,
	output logic                    hblank_n,
	output logic                    vblank_n
);
	import video_timing_pkg::*;

	localparam int div_w = $clog2(pix_div);
	localparam logic [div_w-1:0] div_last = div_w'(pix_div - 1);

	// raster landmarks
	localparam hpos_t h_act    = hpos_t'(h_active);
	localparam hpos_t h_last   = hpos_t'(h_total - 1);
	localparam hpos_t h_end    = hpos_t'(h_total);
	localparam hpos_t hs_start = hpos_t'(h_active + 4);
	localparam hpos_t hs_stop  = hpos_t'(h_active + 8);
	localparam vpos_t v_act    = vpos_t'(v_active);
	localparam vpos_t v_last   = vpos_t'(v_total - 1);
	localparam vpos_t v_end    = vpos_t'(v_total);
	localparam vpos_t vs_start = vpos_t'(v_active + 2);
	localparam vpos_t vs_stop  = vpos_t'(v_active + 4);

	logic [div_w-1:0] div_cnt;

	// 48m divider, enable on last count
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			div_cnt <= '0;
		end else if (div_cnt == div_last) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign pix_ce = (div_cnt == div_last);

	// pixel and line counters
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			hpos <= '0;
			vpos <= '0;
		end else if (pix_ce) begin
			if (hpos == h_last) begin
				hpos <= '0;
				// end of line, step line
				if (vpos == v_last) begin
					vpos <= '0;
				end else begin
					vpos <= vpos + 1'b1;
				end
			end else begin
				hpos <= hpos + 1'b1;
			end
		end
	end

	// blanking from counters
	assign hblank_n = (hpos < h_act);
	assign vblank_n = (vpos < v_act);
	assign active   = hblank_n && vblank_n;

	// hsync 4 px wide, 4 px into hblank
	assign hsync_n = !((hpos >= hs_start) && (hpos < hs_stop));
	// vsync 2 lines wide, 2 lines into vblank
	assign vsync_n = !((vpos >= vs_start) && (vpos < vs_stop));

	// counters stay inside the raster
	a_hpos_range: assert property (@(posedge clk_48m) disable iff (rst_n)
		hpos < h_end);
	a_vpos_range: assert property (@(posedge clk_48m) disable iff (rst_n)
		vpos < v_end);

endmodule

//--- verilog/tile_layer.sv
`timescale 1ns/1ps

module tile_layer (
	input  logic                    clk_48m,
	input  logic                    rst_n,
	input  logic                    pix_ce,
	input  video_timing_pkg::hpos_t hpos,
	input  video_timing_pkg::vpos_t vpos,
	input  logic                    active,
	input  logic                    wr_en,
	input  gfx_pkg::wr_sel_t        wr_sel,
	input  logic [7:0]              wr_addr,
	input  gfx_pkg::host_data_t     wr_data,
	output gfx_pkg::cidx_t          tile_cidx
);
	import gfx_pkg::*;

	localparam int map_depth = map_cols * map_rows;
	localparam int map_aw    = $clog2(map_depth);
	localparam int col_w     = $clog2(map_cols);
	localparam int row_w     = $clog2(map_rows);
	// scroll wraps at map width in pixels
	localparam int sx_w      = col_w + 3;

	logic              map_we;
	logic [map_aw-1:0] map_waddr;
	logic [map_aw-1:0] map_raddr;
	tile_entry_t       map_wdata;
	tile_entry_t       map_entry;
	logic [sx_w-1:0]   scroll_x;
	logic [sx_w-1:0]   sx;
	logic [col_w-1:0]  tile_col;
	logic [row_w-1:0]  tile_row;
	logic              pix_on;

	////////////////////////////////////////////////////////////////////////////
	// host writes
	////////////////////////////////////////////////////////////////////////////

	assign map_we    = wr_en && (wr_sel == sel_tilemap);
	assign map_waddr = wr_addr[map_aw-1:0];
	assign map_wdata = tile_entry_t'(wr_data[$bits(tile_entry_t)-1:0]);

	// horizontal scroll
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			scroll_x <= '0;
		end else if (wr_en && (wr_sel == sel_scroll)) begin
			scroll_x <= wr_data[sx_w-1:0];
		end
	end

	entry_store #(
		.entry_t (tile_entry_t),
		.depth   (map_depth)
	) u_map (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.we      (map_we),
		.waddr   (map_waddr),
		.wdata   (map_wdata),
		.raddr   (map_raddr),
		.rdata   (map_entry)
	);

	////////////////////////////////////////////////////////////////////////////
	// tile fetch and pattern expansion
	////////////////////////////////////////////////////////////////////////////

	// mod 64 add by truncation
	assign sx        = hpos[sx_w-1:0] + scroll_x;
	assign tile_col  = sx[sx_w-1:3];
	assign tile_row  = vpos[row_w+2:3];
	// row major map
	assign map_raddr = {tile_row, tile_col};

	always_comb begin
		case (map_entry.pattern)
			pat_solid:   pix_on = 1'b1;
			pat_empty:   pix_on = 1'b0;
			// alternate pixels, flips each row
			pat_checker: pix_on = sx[0] ^ vpos[0];
			// even rows lit
			pat_stripe:  pix_on = !vpos[0];
			default:     pix_on = 1'b0;
		endcase
	end

	// one pixel behind the raster
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			tile_cidx <= '0;
		end else if (pix_ce) begin
			tile_cidx <= (active && pix_on) ? map_entry.color : '0;
		end
	end

endmodule

//--- verilog/sprite_layer.sv
`timescale 1ns/1ps

module sprite_layer #(
	parameter int num_sprites = 4
) (
	input  logic                    clk_48m,
	input  logic                    rst_n,
	input  logic                    pix_ce,
	input  video_timing_pkg::hpos_t hpos,
	input  video_timing_pkg::vpos_t vpos,
	input  logic                    active,
	input  logic                    wr_en,
	input  gfx_pkg::wr_sel_t        wr_sel,
	input  logic [7:0]              wr_addr,
	input  gfx_pkg::host_data_t     wr_data,
	output gfx_pkg::cidx_t          spr_cidx
);
	import gfx_pkg::*;

	localparam int spr_aw = (num_sprites > 1) ? $clog2(num_sprites) : 1;

	typedef logic [spr_aw-1:0] spr_idx_t;

	logic                   spr_we;
	spr_idx_t               spr_waddr;
	sprite_entry_t          wr_entry;
	sprite_entry_t          rd_entry;
	// position mirror for parallel hit test
	logic [num_sprites-1:0] spr_en;
	logic [5:0]             spr_x [num_sprites];
	logic [4:0]             spr_y [num_sprites];
	logic                   hit_any;
	spr_idx_t               hit_idx;

	////////////////////////////////////////////////////////////////////////////
	// sprite table writes
	////////////////////////////////////////////////////////////////////////////

	// out of range entries dropped
	assign spr_we    = wr_en && (wr_sel == sel_sprite) && (int'(wr_addr) < num_sprites);
	assign spr_waddr = spr_idx_t'(wr_addr);
	assign wr_entry  = sprite_entry_t'(wr_data);

	// addressed table, colour read by winner
	entry_store #(
		.entry_t (sprite_entry_t),
		.depth   (num_sprites)
	) u_table (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.we      (spr_we),
		.waddr   (spr_waddr),
		.wdata   (wr_entry),
		.raddr   (hit_idx),
		.rdata   (rd_entry)
	);

	// mirror copy updated on the same edge
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			spr_en <= '0;
			for (int i = 0; i < num_sprites; i++) begin
				spr_x[i] <= '0;
				spr_y[i] <= '0;
			end
		end else if (spr_we) begin
			spr_en[spr_waddr] <= wr_entry.enable;
			spr_x[spr_waddr]  <= wr_entry.x;
			spr_y[spr_waddr]  <= wr_entry.y;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// hit test
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		logic [7:0] dx;
		logic [7:0] dy;
		hit_any = 1'b0;
		hit_idx = '0;
		// scan downwards so the lowest index is assigned last
		for (int i = num_sprites - 1; i >= 0; i--) begin
			dx = hpos - {2'b00, spr_x[i]};
			dy = vpos - {3'b000, spr_y[i]};
			if (spr_en[i] && (hpos >= {2'b00, spr_x[i]}) && (dx < 8'd8) &&
					(vpos >= {3'b000, spr_y[i]}) && (dy < 8'd8)) begin
				hit_any = 1'b1;
				hit_idx = spr_idx_t'(i);
			end
		end
	end

	// one pixel behind the raster, same as tiles
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			spr_cidx <= '0;
		end else if (pix_ce) begin
			spr_cidx <= (active && hit_any) ? rd_entry.color : '0;
		end
	end

	// host must stay inside the table
	a_spr_addr: assert property (@(posedge clk_48m) disable iff (rst_n)
		(wr_en && (wr_sel == sel_sprite)) |-> (int'(wr_addr) < num_sprites));

endmodule

//--- verilog/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer #(
	parameter int sprite_on_top = 1
) (
	input  logic                clk_48m,
	input  logic                rst_n,
	input  logic                pix_ce,
	input  gfx_pkg::cidx_t      tile_cidx,
	input  gfx_pkg::cidx_t      spr_cidx,
	input  logic                active,
	input  logic                hsync_n,
	input  logic                vsync_n,
	input  logic                hblank_n,
	input  logic                vblank_n,
	input  logic                wr_en,
	input  gfx_pkg::wr_sel_t    wr_sel,
	input  logic [7:0]          wr_addr,
	input  gfx_pkg::host_data_t wr_data,
	output gfx_pkg::rgb_t       vid_rgb,
	output logic                vid_hsync_n,
	output logic                vid_vsync_n,
	output logic                vid_hblank_n,
	output logic                vid_vblank_n
);
	import gfx_pkg::*;

	logic  pal_we;
	rgb_t  pal_wdata;
	rgb_t  pal_rgb;
	cidx_t back_cidx;
	cidx_t top_cidx;
	cidx_t low_cidx;
	cidx_t mix_cidx;
	// stage 1 copies of raster levels
	logic  active_d1;
	logic  hsync_d1;
	logic  vsync_d1;
	logic  hblank_d1;
	logic  vblank_d1;

	////////////////////////////////////////////////////////////////////////////
	// palette and background colour
	////////////////////////////////////////////////////////////////////////////

	assign pal_we    = wr_en && (wr_sel == sel_palette);
	assign pal_wdata = rgb_t'(wr_data[$bits(rgb_t)-1:0]);

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			back_cidx <= '0;
		end else if (wr_en && (wr_sel == sel_backcolor)) begin
			back_cidx <= wr_data[$bits(cidx_t)-1:0];
		end
	end

	entry_store #(
		.entry_t (rgb_t),
		.depth   (16)
	) u_palette (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.we      (pal_we),
		.waddr   (wr_addr[3:0]),
		.wdata   (pal_wdata),
		.raddr   (mix_cidx),
		.rdata   (pal_rgb)
	);

	////////////////////////////////////////////////////////////////////////////
	// priority merge
	////////////////////////////////////////////////////////////////////////////

	assign top_cidx = (sprite_on_top != 0) ? spr_cidx : tile_cidx;
	assign low_cidx = (sprite_on_top != 0) ? tile_cidx : spr_cidx;

	// first opaque layer, else background
	always_comb begin
		if (top_cidx != '0) begin
			mix_cidx = top_cidx;
		end else if (low_cidx != '0) begin
			mix_cidx = low_cidx;
		end else begin
			mix_cidx = back_cidx;
		end
	end

	// raster levels, first pixel of delay
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			active_d1 <= 1'b0;
			hsync_d1  <= 1'b1;
			vsync_d1  <= 1'b1;
			hblank_d1 <= 1'b1;
			vblank_d1 <= 1'b1;
		end else if (pix_ce) begin
			active_d1 <= active;
			hsync_d1  <= hsync_n;
			vsync_d1  <= vsync_n;
			hblank_d1 <= hblank_n;
			vblank_d1 <= vblank_n;
		end
	end

	// output stage, lines up with layer indices
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			vid_rgb      <= '0;
			vid_hsync_n  <= 1'b1;
			vid_vsync_n  <= 1'b1;
			vid_hblank_n <= 1'b1;
			vid_vblank_n <= 1'b1;
		end else if (pix_ce) begin
			// black while blanked
			vid_rgb      <= active_d1 ? pal_rgb : '0;
			vid_hsync_n  <= hsync_d1;
			vid_vsync_n  <= vsync_d1;
			vid_hblank_n <= hblank_d1;
			vid_vblank_n <= vblank_d1;
		end
	end

	// colour gate and blank outputs come from different timing paths
	a_blank_black: assert property (@(posedge clk_48m) disable iff (rst_n)
		(!vid_hblank_n || !vid_vblank_n) |-> (vid_rgb == '0));

endmodule

//--- verilog/video_top.sv
`timescale 1ns/1ps

module video_top #(
	parameter int h_active      = 32,
	parameter int h_total       = 48,
	parameter int v_active      = 16,
	parameter int v_total       = 24,
	parameter int num_sprites   = 4,
	parameter int sprite_on_top = 1
) (
	input  logic                clk_48m,
	input  logic                rst_n,
	input  logic                wr_en,
	input  gfx_pkg::wr_sel_t    wr_sel,
	input  logic [7:0]          wr_addr,
	input  gfx_pkg::host_data_t wr_data,
	output logic                vid_ce,
	output gfx_pkg::rgb_t       vid_rgb,
	output logic                vid_hsync_n,
	output logic                vid_vsync_n,
	output logic                vid_hblank_n,
	output logic                vid_vblank_n
);
	import video_timing_pkg::*;
	import gfx_pkg::*;

	// raster from timing generator
	logic  pix_ce;
	hpos_t hpos;
	vpos_t vpos;
	logic  active;
	logic  hsync_n;
	logic  vsync_n;
	logic  hblank_n;
	logic  vblank_n;
	// layer colour indices, one pixel late
	cidx_t tile_cidx;
	cidx_t spr_cidx;

	video_timing #(
		.h_active (h_active),
		.h_total  (h_total),
		.v_active (v_active),
		.v_total  (v_total)
	) u_timing (
		.clk_48m  (clk_48m),
		.rst_n    (rst_n),
		.pix_ce   (pix_ce),
		.hpos     (hpos),
		.vpos     (vpos),
		.active   (active),
		.hsync_n  (hsync_n),
		.vsync_n  (vsync_n),
		.hblank_n (hblank_n),
		.vblank_n (vblank_n)
	);

	tile_layer u_tile (
		.clk_48m   (clk_48m),
		.rst_n     (rst_n),
		.pix_ce    (pix_ce),
		.hpos      (hpos),
		.vpos      (vpos),
		.active    (active),
		.wr_en     (wr_en),
		.wr_sel    (wr_sel),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.tile_cidx (tile_cidx)
	);

	sprite_layer #(
		.num_sprites (num_sprites)
	) u_sprite (
		.clk_48m  (clk_48m),
		.rst_n    (rst_n),
		.pix_ce   (pix_ce),
		.hpos     (hpos),
		.vpos     (vpos),
		.active   (active),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.spr_cidx (spr_cidx)
	);

	pixel_mixer #(
		.sprite_on_top (sprite_on_top)
	) u_mixer (
		.clk_48m      (clk_48m),
		.rst_n        (rst_n),
		.pix_ce       (pix_ce),
		.tile_cidx    (tile_cidx),
		.spr_cidx     (spr_cidx),
		.active       (active),
		.hsync_n      (hsync_n),
		.vsync_n      (vsync_n),
		.hblank_n     (hblank_n),
		.vblank_n     (vblank_n),
		.wr_en        (wr_en),
		.wr_sel       (wr_sel),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.vid_rgb      (vid_rgb),
		.vid_hsync_n  (vid_hsync_n),
		.vid_vsync_n  (vid_vsync_n),
		.vid_hblank_n (vid_hblank_n),
		.vid_vblank_n (vid_vblank_n)
	);

	// pixel strobe for capture
	assign vid_ce = pix_ce;

endmodule

//--- tb/video_checker.sv
`timescale 1ns/1ps

module video_checker #(
	parameter int h_active      = 32,
	parameter int h_total       = 48,
	parameter int v_active      = 16,
	parameter int v_total       = 24,
	parameter int num_sprites   = 4,
	parameter int sprite_on_top = 1
) (
	input  logic                clk_48m,
	input  logic                rst_n,
	input  logic                wr_en,
	input  gfx_pkg::wr_sel_t    wr_sel,
	input  logic [7:0]          wr_addr,
	input  gfx_pkg::host_data_t wr_data,
	input  logic                vid_ce,
	input  gfx_pkg::rgb_t       vid_rgb,
	input  logic                vid_hsync_n,
	input  logic                vid_vsync_n,
	input  logic                vid_hblank_n,
	input  logic                vid_vblank_n,
	input  logic                spot_en,
	input  logic [7:0]          spot_x,
	input  logic [7:0]          spot_y,
	input  gfx_pkg::rgb_t       spot_rgb,
	output int                  error_count,
	output int                  frames_checked
);
	import gfx_pkg::*;

	// shadow of host-written state
	tile_entry_t   map_sh [map_cols * map_rows];
	sprite_entry_t spr_sh [num_sprites];
	rgb_t          pal_sh [16];
	logic [5:0]    scroll_sh;
	cidx_t         back_sh;

	// raster position recovered from the output levels
	int x;
	int y;
	int h_cnt;
	int v_cnt;
	bit prev_hb;
	bit prev_vb;
	bit line_seen;
	bit pos_valid;
	bit rst_prev = 1'b0;

	initial begin
		error_count    = 0;
		frames_checked = 0;
	end

	task automatic check_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h actual %h (x %0d y %0d)",
				name, exp, act, x, y);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic rgb_t expect_rgb(input int px, input int py);
		int          sx;
		tile_entry_t t;
		bit          on;
		cidx_t       tc;
		cidx_t       sc;
		cidx_t       idx;
		bit          found;
		if (px >= h_active || py >= v_active) begin
			return '0;
		end
		// scroll wraps at the 64 pixel map width
		sx = (px + int'(scroll_sh)) % 64;
		t  = map_sh[((py / 8) % map_rows) * map_cols + sx / 8];
		case (t.pattern)
			pat_solid:   on = 1'b1;
			pat_empty:   on = 1'b0;
			pat_checker: on = ((sx % 2) != (py % 2));
			default:     on = ((py % 2) == 0);
		endcase
		tc = on ? t.color : '0;
		// first enabled sprite covering the pixel
		sc    = '0;
		found = 1'b0;
		for (int i = 0; i < num_sprites; i++) begin
			if (!found && spr_sh[i].enable &&
					px >= int'(spr_sh[i].x) && px < int'(spr_sh[i].x) + 8 &&
					py >= int'(spr_sh[i].y) && py < int'(spr_sh[i].y) + 8) begin
				found = 1'b1;
				sc    = spr_sh[i].color;
			end
		end
		if (sprite_on_top != 0) begin
			idx = (sc != 0) ? sc : ((tc != 0) ? tc : back_sh);
		end else begin
			idx = (tc != 0) ? tc : ((sc != 0) ? sc : back_sh);
		end
		return pal_sh[idx];
	endfunction

	task automatic check_reset_state();
		check_value("vid_rgb", 16'h0, 16'(vid_rgb));
		check_value("vid_hsync_n", 16'h1, 16'(vid_hsync_n));
		check_value("vid_vsync_n", 16'h1, 16'(vid_vsync_n));
		check_value("vid_hblank_n", 16'h1, 16'(vid_hblank_n));
		check_value("vid_vblank_n", 16'h1, 16'(vid_vblank_n));
	endtask

	task automatic snoop_write();
		case (wr_sel)
			sel_tilemap:   map_sh[int'(wr_addr[4:0])] = tile_entry_t'(wr_data[5:0]);
			sel_sprite: begin
				if (int'(wr_addr) < num_sprites) begin
					spr_sh[int'(wr_addr)] = sprite_entry_t'(wr_data);
				end
			end
			sel_palette:   pal_sh[int'(wr_addr[3:0])] = rgb_t'(wr_data[11:0]);
			sel_scroll:    scroll_sh = wr_data[5:0];
			sel_backcolor: back_sh = wr_data[3:0];
			default: ;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per-pixel tracking and comparison
	////////////////////////////////////////////////////////////////////////////

	task automatic track_pixel();
		bit exp_hs;
		bit exp_vs;
		// rising hblank marks pixel 0 of a line
		if (vid_hblank_n && !prev_hb) begin
			if (line_seen) begin
				check_value("vid_ce per line", 16'(h_total), 16'(h_cnt));
			end
			line_seen = 1'b1;
			h_cnt     = 0;
			x         = 0;
			if (vid_vblank_n && !prev_vb) begin
				if (pos_valid) begin
					check_value("lines per frame", 16'(v_total), 16'(v_cnt));
					frames_checked++;
				end
				pos_valid = 1'b1;
				v_cnt     = 0;
				y         = 0;
			end else begin
				y++;
			end
			v_cnt++;
		end else begin
			x++;
		end
		h_cnt++;
		prev_hb = vid_hblank_n;
		prev_vb = vid_vblank_n;

		if (pos_valid) begin
			// hsync 4 px wide from 4 px after active
			// vsync 2 lines wide from 2 lines after active
			exp_hs = !((x >= h_active + 4) && (x < h_active + 8));
			exp_vs = !((y >= v_active + 2) && (y < v_active + 4));
			check_value("vid_hblank_n", 16'(x < h_active), 16'(vid_hblank_n));
			check_value("vid_vblank_n", 16'(y < v_active), 16'(vid_vblank_n));
			check_value("vid_hsync_n", 16'(exp_hs), 16'(vid_hsync_n));
			check_value("vid_vsync_n", 16'(exp_vs), 16'(vid_vsync_n));
			check_value("vid_rgb", 16'(expect_rgb(x, y)), 16'(vid_rgb));
			if (spot_en && x == int'(spot_x) && y == int'(spot_y)) begin
				check_value("vid_rgb spot", 16'(spot_rgb), 16'(vid_rgb));
			end
		end
	endtask

	always @(posedge clk_48m) begin
		if (rst_n) begin
			if (rst_prev) begin
				check_reset_state();
			end
			rst_prev  = 1'b1;
			scroll_sh = '0;
			back_sh   = '0;
			for (int i = 0; i < map_cols * map_rows; i++) begin
				map_sh[i] = '0;
			end
			for (int i = 0; i < num_sprites; i++) begin
				spr_sh[i] = '0;
			end
			for (int i = 0; i < 16; i++) begin
				pal_sh[i] = '0;
			end
			prev_hb   = 1'b1;
			prev_vb   = 1'b1;
			line_seen = 1'b0;
			pos_valid = 1'b0;
			x         = 0;
			y         = 0;
			h_cnt     = 0;
			v_cnt     = 0;
		end else begin
			// outputs still hold reset values on the first edge out of reset
			if (rst_prev) begin
				check_reset_state();
			end
			rst_prev = 1'b0;
			if (vid_ce) begin
				track_pixel();
			end
			if (wr_en) begin
				snoop_write();
			end
		end
	end

endmodule

//--- tb/tb_video_top.sv
`timescale 1ns/1ps

module tb_video_top;
	import gfx_pkg::*;

	localparam int h_active      = 32;
	localparam int h_total       = 48;
	localparam int v_active      = 16;
	localparam int v_total       = 24;
	localparam int num_sprites   = 4;
	localparam int sprite_on_top = 1;
	// two frames of master clocks
	localparam int wait_limit    = 2 * h_total * v_total * 8;

	// one table row, either a write or the start of a phase with its spot value
	typedef struct packed {
		logic       mark;
		wr_sel_t    sel;
		logic [7:0] addr;
		host_data_t data;
		logic [7:0] spot_x;
		logic [7:0] spot_y;
		rgb_t       spot_rgb;
	} step_t;

	logic       clk_48m;
	logic       rst_n;
	logic       wr_en;
	wr_sel_t    wr_sel;
	logic [7:0] wr_addr;
	host_data_t wr_data;
	logic       vid_ce;
	rgb_t       vid_rgb;
	logic       vid_hsync_n;
	logic       vid_vsync_n;
	logic       vid_hblank_n;
	logic       vid_vblank_n;
	logic       spot_en;
	logic [7:0] spot_x;
	logic [7:0] spot_y;
	rgb_t       spot_rgb;
	int         error_count;
	int         frames_checked;
	int         timeouts;
	int         num_phases;
	integer     seed;
	step_t      steps [$];

	video_top #(
		.h_active      (h_active),
		.h_total       (h_total),
		.v_active      (v_active),
		.v_total       (v_total),
		.num_sprites   (num_sprites),
		.sprite_on_top (sprite_on_top)
	) u_dut (
		.clk_48m      (clk_48m),
		.rst_n        (rst_n),
		.wr_en        (wr_en),
		.wr_sel       (wr_sel),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.vid_ce       (vid_ce),
		.vid_rgb      (vid_rgb),
		.vid_hsync_n  (vid_hsync_n),
		.vid_vsync_n  (vid_vsync_n),
		.vid_hblank_n (vid_hblank_n),
		.vid_vblank_n (vid_vblank_n)
	);

	video_checker #(
		.h_active      (h_active),
		.h_total       (h_total),
		.v_active      (v_active),
		.v_total       (v_total),
		.num_sprites   (num_sprites),
		.sprite_on_top (sprite_on_top)
	) u_chk (
		.clk_48m        (clk_48m),
		.rst_n          (rst_n),
		.wr_en          (wr_en),
		.wr_sel         (wr_sel),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.vid_ce         (vid_ce),
		.vid_rgb        (vid_rgb),
		.vid_hsync_n    (vid_hsync_n),
		.vid_vsync_n    (vid_vsync_n),
		.vid_hblank_n   (vid_hblank_n),
		.vid_vblank_n   (vid_vblank_n),
		.spot_en        (spot_en),
		.spot_x         (spot_x),
		.spot_y         (spot_y),
		.spot_rgb       (spot_rgb),
		.error_count    (error_count),
		.frames_checked (frames_checked)
	);

	// 50 MHz stand-in for the 48 MHz master clock
	initial begin
		clk_48m = 1'b0;
		forever #10 clk_48m = ~clk_48m;
	end

	////////////////////////////////////////////////////////////////////////////
	// write table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_write(input wr_sel_t sel, input int addr, input host_data_t data);
		step_t s;
		s      = '0;
		s.sel  = sel;
		s.addr = 8'(addr);
		s.data = data;
		steps.push_back(s);
	endtask

	// phase start, plus the hand-derived colour of one pixel in the next frame
	task automatic add_phase(input int px, input int py, input rgb_t exp);
		step_t s;
		s          = '0;
		s.mark     = 1'b1;
		s.spot_x   = 8'(px);
		s.spot_y   = 8'(py);
		s.spot_rgb = exp;
		steps.push_back(s);
		num_phases++;
	endtask

	task automatic build_table();
		rgb_t rnd_pal [16];
		// palette i is blue i, green 15-i, red i; background 5; tile i colour i%15+1
		add_phase(0, 0, rgb_t'(12'h1e1));
		for (int i = 0; i < 16; i++) begin
			add_write(sel_palette, i, 16'({4'(i), 4'(15 - i), 4'(i)}));
		end
		add_write(sel_backcolor, 0, 16'd5);
		add_write(sel_scroll, 0, 16'd0);
		for (int i = 0; i < map_cols * map_rows; i++) begin
			add_write(sel_tilemap, i, 16'({4'((i % 15) + 1), 2'(i % 4)}));
		end
		// scroll 45, x 20 wraps to tile 0
		add_phase(20, 3, rgb_t'(12'h1e1));
		add_write(sel_scroll, 0, 16'd45);
		// sprites 0 and 1 overlap, 2 disabled, 3 clipped at the edges
		add_phase(9, 7, rgb_t'(12'h969));
		add_write(sel_sprite, 0, {1'b1, 6'd4, 5'd2, 4'd9});
		add_write(sel_sprite, 1, {1'b1, 6'd8, 5'd6, 4'd12});
		add_write(sel_sprite, 2, {1'b0, 6'd20, 5'd4, 4'd7});
		add_write(sel_sprite, 3, {1'b1, 6'd28, 5'd12, 4'd3});
		// empty tile 1 shows background colour 11
		add_phase(8, 0, rgb_t'(12'hb4b));
		add_write(sel_scroll, 0, 16'd0);
		add_write(sel_backcolor, 0, 16'd11);
		add_write(sel_sprite, 0, {1'b0, 6'd4, 5'd2, 4'd9});
		// random palette
		for (int i = 0; i < 16; i++) begin
			rnd_pal[i] = rgb_t'(12'($random(seed)));
		end
		add_phase(8, 0, rnd_pal[11]);
		for (int i = 0; i < 16; i++) begin
			add_write(sel_palette, i, 16'(rnd_pal[i]));
		end
	endtask

	// high then low, each with its own limit
	task automatic wait_vsync_fall(output bit ok);
		int n;
		ok = 1'b1;
		n  = 0;
		while (vid_vsync_n !== 1'b1 && n < wait_limit) begin
			@(posedge clk_48m);
			n++;
		end
		if (vid_vsync_n !== 1'b1) begin
			$display("timeout: vid_vsync_n did not go high");
			timeouts++;
			ok = 1'b0;
		end else begin
			n = 0;
			while (vid_vsync_n !== 1'b0 && n < wait_limit) begin
				@(posedge clk_48m);
				n++;
			end
			if (vid_vsync_n !== 1'b0) begin
				$display("timeout: vid_vsync_n did not go low");
				timeouts++;
				ok = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		bit    ok;
		int    i;
		int    run_errors;
		step_t s;
		rst_n      = 1'b1;
		wr_en      = 1'b0;
		wr_sel     = sel_tilemap;
		wr_addr    = '0;
		wr_data    = '0;
		spot_en    = 1'b0;
		spot_x     = '0;
		spot_y     = '0;
		spot_rgb   = '0;
		timeouts   = 0;
		num_phases = 0;
		run_errors = 0;
		seed       = 32'h0c07337a;
		build_table();

		// reset asserted high for 5 cycles
		repeat (5) @(posedge clk_48m);
		rst_n <= 1'b0;

		ok = 1'b1;
		i  = 0;
		while (ok && i < steps.size()) begin
			s = steps[i];
			@(posedge clk_48m);
			if (s.mark) begin
				// new phase starts in vertical blanking
				wr_en <= 1'b0;
				wait_vsync_fall(ok);
				if (ok) begin
					spot_en  <= 1'b1;
					spot_x   <= s.spot_x;
					spot_y   <= s.spot_y;
					spot_rgb <= s.spot_rgb;
				end
			end else begin
				wr_en   <= 1'b1;
				wr_sel  <= s.sel;
				wr_addr <= s.addr;
				wr_data <= s.data;
			end
			i++;
		end
		@(posedge clk_48m);
		wr_en <= 1'b0;

		// last phase on screen, then one spare frame
		if (ok) begin
			wait_vsync_fall(ok);
		end
		if (ok) begin
			wait_vsync_fall(ok);
		end
		if (frames_checked < num_phases) begin
			$display("checker compared only %0d frames", frames_checked);
			run_errors++;
		end

		$display("errors %0d, timeouts %0d", error_count + run_errors, timeouts);
		if (error_count + run_errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- verilog.f
verilog/video_timing_pkg.sv
verilog/gfx_pkg.sv
verilog/entry_store.sv
verilog/video_timing.sv
verilog/tile_layer.sv
verilog/sprite_layer.sv
verilog/pixel_mixer.sv
verilog/video_top.sv
tb/video_checker.sv
tb/tb_video_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_top -f verilog.f -o tb_video_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_video_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -F -x -q '** PASS **'; then
	exit 0
fi
exit 1
